// ==== Bender.yml ====
package:
  name: board_harness

sources:
  - logic/boardPkg.sv
  - logic/decadeTicks.sv
  - logic/inputSampler.sv
  - logic/reloadTimer.sv
  - logic/displaySelect.sv
  - logic/segScan.sv
  - logic/boardTop.sv
  - target: test
    files:
      - verif/boardTb.sv

// ==== flist.f ====
logic/boardPkg.sv
logic/decadeTicks.sv
logic/inputSampler.sv
logic/reloadTimer.sv
logic/displaySelect.sv
logic/segScan.sv
logic/boardTop.sv
verif/boardTb.sv

// ==== logic/boardPkg.sv ====
package boardPkg;

   // Rate for the timer count enable. Codes past the last decade stage hold the timer.
   typedef enum logic [3:0]
   {
      rateEvery   = 4'd0,
      rateDiv10   = 4'd1,
      rateDiv100  = 4'd2,
      rateDiv1k   = 4'd3,
      rateDiv10k  = 4'd4,
      rateDiv100k = 4'd5,
      rateDiv1M   = 4'd6,
      rateHold    = 4'd7
   } rateSelT;

   typedef enum logic [2:0]
   {
      dispTimer    = 3'd0,
      dispArr      = 3'd1,
      dispCtr      = 3'd2,
      dispClkTest  = 3'd3,
      dispSwitches = 3'd4,
      dispButtons  = 3'd5,
      dispStatus   = 3'd6,
      dispPattern  = 3'd7
   } dispSelT;

   typedef enum logic [1:0]
   {
      cmdNone      = 2'd0,
      cmdLoadArr   = 2'd1,
      cmdClear     = 2'd2,
      cmdToggleRun = 2'd3
   } timerCmdT;

   // Bit positions in the sampled button vector.
   localparam int BtnC = 0;
   localparam int BtnD = 1;
   localparam int BtnU = 2;
   localparam int BtnR = 3;
   localparam int BtnL = 4;

   localparam int DigitCount = 4;

   typedef struct packed
   {
      logic [15:0] sw;
      logic [4:0]  btn;
      rateSelT     rateSel;
      dispSelT     dispSel;
   } inputsT;

   typedef struct packed
   {
      logic [31:0] tmr;
      logic [31:0] arr;
      logic [31:0] ctr;
      logic        running;
      logic        arReached;
      logic        reserved;
   } timerStatT;

endpackage

// ==== logic/boardTop.sv ====
`timescale 1ns/1ps

module boardTop #(
   parameter int DecadeStages = 6,
   parameter int SampleDiv    = 1000,
   parameter int ScanDiv      = 100
) (
   input  logic        selected_clk,
   input  logic        res,
   input  logic [15:0] sw,
   input  logic        btnC,
   input  logic        btnU,
   input  logic        btnD,
   input  logic        btnL,
   input  logic        btnR,
   output logic [15:0] leds,
   output logic [7:0]  seg,
   output logic [3:0]  an
);

   logic                countEn;
   logic                sampleTick;
   logic                scanTick;
   boardPkg::inputsT    inputs;
   boardPkg::timerCmdT  cmd;
   boardPkg::timerStatT status;
   logic [31:0]         clkTest;
   logic [31:0]         dispWord;

   //////////////////////////////
   // Input side
   //////////////////////////////
   decadeTicks #(
      .DecadeStages (DecadeStages),
      .SampleDiv    (SampleDiv),
      .ScanDiv      (ScanDiv)
   ) ticks (
      .selected_clk (selected_clk),
      .res          (res),
      .rateSel      (inputs.rateSel),
      .countEn      (countEn),
      .sampleTick   (sampleTick),
      .scanTick     (scanTick)
   );

   inputSampler sampler (
      .selected_clk (selected_clk),
      .res          (res),
      .sampleTick   (sampleTick),
      .sw           (sw),
      .btnC         (btnC),
      .btnU         (btnU),
      .btnD         (btnD),
      .btnL         (btnL),
      .btnR         (btnR),
      .inputs       (inputs),
      .cmd          (cmd)
   );

   //////////////////////////////
   // Timer and display
   //////////////////////////////
   reloadTimer timer (
      .selected_clk (selected_clk),
      .res          (res),
      .countEn      (countEn),
      .cmd          (cmd),
      .loadValue    (inputs.sw),
      .status       (status),
      .clkTest      (clkTest)
   );

   displaySelect dispMux (
      .selected_clk (selected_clk),
      .res          (res),
      .dispSel      (inputs.dispSel),
      .status       (status),
      .clkTest      (clkTest),
      .inputs       (inputs),
      .dispWord     (dispWord)
   );

   segScan scan (
      .selected_clk (selected_clk),
      .res          (res),
      .scanTick     (scanTick),
      .dispWord     (dispWord),
      .seg          (seg),
      .an           (an)
   );

   assign leds = inputs.sw;   // Mirror of the sampled switches.

endmodule

// ==== logic/decadeTicks.sv ====
`timescale 1ns/1ps

module decadeTicks #(
   parameter int DecadeStages = 6,
   parameter int SampleDiv    = 1000,
   parameter int ScanDiv      = 100
) (
   input  logic              selected_clk,
   input  logic              res,
   input  boardPkg::rateSelT rateSel,
   output logic              countEn,
   output logic              sampleTick,
   output logic              scanTick
);

   localparam int SampleW = (SampleDiv > 1) ? $clog2(SampleDiv) : 1;
   localparam int ScanW   = (ScanDiv > 1) ? $clog2(ScanDiv) : 1;

   logic [3:0]              decCnt [DecadeStages];
   logic [DecadeStages-1:0] stageEn;
   logic [DecadeStages-1:0] stageWrap;
   logic [DecadeStages-1:0] stageTick;
   logic [SampleW-1:0]      sampleCnt;
   logic [ScanW-1:0]        scanCnt;

   //////////////////////////////
   // Decade chain
   //////////////////////////////
   always_comb
   begin
      stageEn[0]   = 1'b1;
      stageWrap[0] = (decCnt[0] == 4'd9);
      for (int i = 1; i < DecadeStages; i++)
      begin
         stageEn[i]   = stageWrap[i-1];   // Carry from the stage below.
         stageWrap[i] = stageEn[i] && (decCnt[i] == 4'd9);
      end
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         for (int i = 0; i < DecadeStages; i++)
            decCnt[i] <= 4'd0;
         stageTick <= '0;
      end
      else
      begin
         for (int i = 0; i < DecadeStages; i++)
         begin
            if (stageWrap[i])
               decCnt[i] <= 4'd0;
            else if (stageEn[i])
               decCnt[i] <= decCnt[i] + 4'd1;
         end
         stageTick <= stageWrap;   // One cycle per wrap.
      end
   end

   always_comb
   begin
      if (rateSel == boardPkg::rateEvery)
         countEn = 1'b1;
      else if (int'(rateSel) <= DecadeStages)
         countEn = stageTick[int'(rateSel) - 1];
      else
         countEn = 1'b0;   // Past the last stage.
   end

   //////////////////////////////
   // Sample and scan ticks
   //////////////////////////////
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         sampleCnt  <= '0;
         scanCnt    <= '0;
         sampleTick <= 1'b0;
         scanTick   <= 1'b0;
      end
      else
      begin
         sampleTick <= (sampleCnt == SampleW'(SampleDiv - 1));
         scanTick   <= (scanCnt == ScanW'(ScanDiv - 1));
         if (sampleCnt == SampleW'(SampleDiv - 1))
            sampleCnt <= '0;
         else
            sampleCnt <= sampleCnt + 1'b1;
         if (scanCnt == ScanW'(ScanDiv - 1))
            scanCnt <= '0;
         else
            scanCnt <= scanCnt + 1'b1;
      end
   end

endmodule

// ==== logic/displaySelect.sv ====
`timescale 1ns/1ps

module displaySelect (
   input  logic                selected_clk,
   input  logic                res,
   input  boardPkg::dispSelT   dispSel,
   input  boardPkg::timerStatT status,
   input  logic [31:0]         clkTest,
   input  boardPkg::inputsT    inputs,
   output logic [31:0]         dispWord
);

   logic [31:0] patternWord;
   logic [31:0] nextWord;

   // Lamp test, digit i shows DigitCount-1-i.
   always_comb
   begin
      patternWord = '0;
      for (int i = 0; i < boardPkg::DigitCount; i++)
         patternWord[4*i +: 4] = 4'(boardPkg::DigitCount - 1 - i);
   end

   always_comb
   begin
      nextWord = '0;
      case (dispSel)
         boardPkg::dispTimer:    nextWord = status.tmr;
         boardPkg::dispArr:      nextWord = status.arr;
         boardPkg::dispCtr:      nextWord = status.ctr;
         boardPkg::dispClkTest:  nextWord = clkTest;
         boardPkg::dispSwitches: nextWord = {16'd0, inputs.sw};
         boardPkg::dispButtons:  nextWord = {27'd0, inputs.btn};
         boardPkg::dispStatus:   nextWord = {30'd0, status.arReached, status.running};
         boardPkg::dispPattern:  nextWord = patternWord;
      endcase
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         dispWord <= '0;
      else
         dispWord <= nextWord;
   end

endmodule

// ==== logic/inputSampler.sv ====
`timescale 1ns/1ps

module inputSampler (
   input  logic               selected_clk,
   input  logic               res,
   input  logic               sampleTick,
   input  logic [15:0]        sw,
   input  logic               btnC,
   input  logic               btnU,
   input  logic               btnD,
   input  logic               btnL,
   input  logic               btnR,
   output boardPkg::inputsT   inputs,
   output boardPkg::timerCmdT cmd
);

   logic [4:0]         prevBtn;
   logic [4:0]         btnRise;
   boardPkg::timerCmdT nextCmd;

   // Slow sampling doubles as debounce.
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         inputs <= '0;
      else if (sampleTick)
      begin
         inputs.sw      <= sw;
         inputs.btn     <= {btnL, btnR, btnU, btnD, btnC};
         inputs.rateSel <= boardPkg::rateSelT'(sw[15:12]);
         inputs.dispSel <= boardPkg::dispSelT'(sw[10:8]);
      end
   end

   assign btnRise = inputs.btn & ~prevBtn;

   // Load wins over clear, clear over toggle.
   always_comb
   begin
      if (btnRise[boardPkg::BtnU])
         nextCmd = boardPkg::cmdLoadArr;
      else if (btnRise[boardPkg::BtnD])
         nextCmd = boardPkg::cmdClear;
      else if (btnRise[boardPkg::BtnC])
         nextCmd = boardPkg::cmdToggleRun;
      else
         nextCmd = boardPkg::cmdNone;
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         prevBtn <= '0;
         cmd     <= boardPkg::cmdNone;
      end
      else
      begin
         prevBtn <= inputs.btn;
         cmd     <= nextCmd;   // One-cycle strobe.
      end
   end

endmodule

// ==== logic/reloadTimer.sv ====
`timescale 1ns/1ps

module reloadTimer (
   input  logic                selected_clk,
   input  logic                res,
   input  logic                countEn,
   input  boardPkg::timerCmdT  cmd,
   input  logic [15:0]         loadValue,
   output boardPkg::timerStatT status,
   output logic [31:0]         clkTest
);

   logic [31:0] tmr;
   logic [31:0] arr;
   logic [31:0] ctr;
   logic        running;
   logic        arReached;
   logic        countStep;
   logic        reloadHit;

   //////////////////////////////
   // Count and reload
   //////////////////////////////
   always_comb
   begin
      countStep = running && countEn
                  && (cmd != boardPkg::cmdLoadArr) && (cmd != boardPkg::cmdClear);
      reloadHit = countStep && (tmr == arr);
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         tmr       <= '0;
         arr       <= '0;
         ctr       <= '0;
         running   <= 1'b0;
         arReached <= 1'b0;
      end
      else
      begin
         arReached <= reloadHit;
         case (cmd)
            boardPkg::cmdLoadArr:
            begin
               arr <= {16'd0, loadValue};
               tmr <= '0;
            end
            boardPkg::cmdClear:
            begin
               tmr <= '0;
               ctr <= '0;
            end
            default:
            begin
               if (reloadHit)
               begin
                  tmr <= '0;           // Wrap back to zero.
                  ctr <= ctr + 32'd1;
               end
               else if (countStep)
                  tmr <= tmr + 32'd1;
            end
         endcase
         if (cmd == boardPkg::cmdToggleRun)
            running <= ~running;
      end
   end

   // Activity counter, independent of the run flag.
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         clkTest <= '0;
      else if (countEn)
         clkTest <= clkTest + 32'd1;
   end

   assign status.tmr       = tmr;
   assign status.arr       = arr;
   assign status.ctr       = ctr;
   assign status.running   = running;
   assign status.arReached = arReached;
   assign status.reserved  = 1'b0;

endmodule

// ==== logic/segScan.sv ====
`timescale 1ns/1ps

module segScan (
   input  logic                              selected_clk,
   input  logic                              res,
   input  logic                              scanTick,
   input  logic [31:0]                       dispWord,
   output logic [7:0]                        seg,
   output logic [boardPkg::DigitCount-1:0]   an
);

   localparam int IdxW = $clog2(boardPkg::DigitCount);

   logic [IdxW-1:0]                 digit;
   logic                            scanning;
   logic [3:0]                      nibble;
   logic [boardPkg::DigitCount-1:0] digitOneHot;

   // Active low, bit order g..a.
   function automatic logic [6:0] hexToSeg(input logic [3:0] hex);
      case (hex)
         4'h0: return 7'h40;
         4'h1: return 7'h79;
         4'h2: return 7'h24;
         4'h3: return 7'h30;
         4'h4: return 7'h19;
         4'h5: return 7'h12;
         4'h6: return 7'h02;
         4'h7: return 7'h78;
         4'h8: return 7'h00;
         4'h9: return 7'h10;
         4'hA: return 7'h08;
         4'hB: return 7'h03;
         4'hC: return 7'h46;
         4'hD: return 7'h21;
         4'hE: return 7'h06;
         default: return 7'h0E;
      endcase
   endfunction

   assign nibble = dispWord[4*digit +: 4];   // Digit 0 is the low nibble.

   always_comb
   begin
      digitOneHot        = '0;
      digitOneHot[digit] = 1'b1;
   end

   //////////////////////////////
   // Digit scan
   //////////////////////////////
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         digit    <= '0;
         scanning <= 1'b0;
         seg      <= '1;
         an       <= '1;   // Blank until the first scan.
      end
      else
      begin
         if (scanTick)
         begin
            digit    <= digit + 1'b1;
            scanning <= 1'b1;
         end
         if (scanning)
         begin
            seg <= {1'b1, hexToSeg(nibble)};   // Dot off.
            an  <= ~digitOneHot;
         end
      end
   end

endmodule

// ==== verif/boardTb.sv ====
`timescale 1ns/1ps

module boardTb;

   localparam int ClkPeriod   = 100;
   localparam int ResetCycles = 5;
   localparam int Stages      = 3;
   localparam int SampleDiv   = 4;
   localparam int ScanDiv     = 3;
   localparam int PressHold   = 8;    // Two sample periods per level.
   localparam int LoadRounds  = 6;
   localparam int ViewCycles  = 24;
   localparam int RunCycles   = 40;
   localparam int PressRounds = 20;
   localparam int RateRounds  = 12;
   localparam int RateMaxHold = 288;
   localparam int TestCycles  = ResetCycles + LoadRounds * (2 * PressHold + ViewCycles)
                              + 4 * PressHold + 3 * RunCycles + PressRounds * 2 * PressHold
                              + RateRounds * RateMaxHold + ViewCycles;
   localparam int Margin      = 200;

   logic        selected_clk = 1'b0;
   logic        res;
   logic [15:0] sw;
   logic        btnC;
   logic        btnU;
   logic        btnD;
   logic        btnL;
   logic        btnR;
   logic [15:0] leds;
   logic [7:0]  seg;
   logic [3:0]  an;

   // Reference model state.
   int unsigned        mCyc;
   logic [Stages-1:0]  mStage;
   logic               mSampleTick;
   logic               mScanTick;
   logic [15:0]        mSw;
   logic [4:0]         mBtn;
   logic [4:0]         mPrevBtn;
   logic [3:0]         mRate;
   logic [2:0]         mDisp;
   boardPkg::timerCmdT mCmd;
   logic [31:0]        mTmr;
   logic [31:0]        mArr;
   logic [31:0]        mCtr;
   logic [31:0]        mClkTest;
   logic [31:0]        mDispWord;
   logic               mRunning;
   logic               mArReached;
   logic [1:0]         mDigit;
   logic               mScanning;
   logic               mScanOn;
   logic [7:0]         mSeg;
   logic [3:0]         mAn;

   int          errors;
   logic [31:0] rng;
   logic        checksOn;
   int unsigned lastReach;
   logic        periodClean;
   int          periodsChecked;

   boardTop #(
      .DecadeStages (Stages),
      .SampleDiv    (SampleDiv),
      .ScanDiv      (ScanDiv)
   ) UUT (
      .selected_clk (selected_clk),
      .res          (res),
      .sw           (sw),
      .btnC         (btnC),
      .btnU         (btnU),
      .btnD         (btnD),
      .btnL         (btnL),
      .btnR         (btnR),
      .leds         (leds),
      .seg          (seg),
      .an           (an)
   );

   always #(ClkPeriod / 2) selected_clk = ~selected_clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int decadePeriod(input int stage);
      int p;
      p = 10;
      for (int k = 0; k < stage; k++)
         p = p * 10;
      return p;
   endfunction

   function automatic logic rateEnable(input logic [3:0] rate, input logic [Stages-1:0] ticks);
      if (rate == 4'd0)
         return 1'b1;
      else if (rate <= Stages)
         return ticks[rate - 1];
      return 1'b0;   // Beyond the last stage.
   endfunction

   // Segments a..g in bits 0..6 and returned active low.
   function automatic logic [6:0] segPattern(input logic [3:0] hex);
      logic [6:0] lit;
      case (hex)
         4'h0: lit = 7'h3F;
         4'h1: lit = 7'h06;
         4'h2: lit = 7'h5B;
         4'h3: lit = 7'h4F;
         4'h4: lit = 7'h66;
         4'h5: lit = 7'h6D;
         4'h6: lit = 7'h7D;
         4'h7: lit = 7'h07;
         4'h8: lit = 7'h7F;
         4'h9: lit = 7'h6F;
         4'hA: lit = 7'h77;
         4'hB: lit = 7'h7C;
         4'hC: lit = 7'h39;
         4'hD: lit = 7'h5E;
         4'hE: lit = 7'h79;
         default: lit = 7'h71;
      endcase
      return ~lit;
   endfunction

   task automatic reportMismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
      errors++;
      $display("ERROR %s: got %h, expected %h", name, got, expected);
   endtask

   task automatic driveFor(input logic [15:0] swVal, input logic [4:0] btnMask, input int cycles);
      @(posedge selected_clk);
      sw                             <= swVal;
      {btnL, btnR, btnU, btnD, btnC} <= btnMask;
      repeat (cycles - 1) @(posedge selected_clk);
   endtask

   task automatic press(input logic [15:0] swVal, input logic [4:0] btnMask);
      driveFor(swVal, btnMask, PressHold);
      driveFor(swVal, 5'b00000, PressHold);
   endtask

   task automatic resetModel();
      mCyc        = 0;
      mStage      = '0;
      mSampleTick = 1'b0;
      mScanTick   = 1'b0;
      mSw         = '0;
      mBtn        = '0;
      mPrevBtn    = '0;
      mRate       = '0;
      mDisp       = '0;
      mCmd        = boardPkg::cmdNone;
      mTmr        = '0;
      mArr        = '0;
      mCtr        = '0;
      mClkTest    = '0;
      mDispWord   = '0;
      mRunning    = 1'b0;
      mArReached  = 1'b0;
      mDigit      = '0;
      mScanning   = 1'b0;
      mScanOn     = 1'b0;
      mSeg        = 8'hFF;
      mAn         = 4'hF;
   endtask

   //////////////////////////////
   // Reference model for one clock
   //////////////////////////////
   // Later pipeline stages go first so that every stage reads old values.
   task automatic stepModel();
      logic       countEn;
      logic       step;
      logic       hit;
      logic [4:0] rise;
      countEn = rateEnable(mRate, mStage);
      if (mScanning)
      begin
         mSeg    = {1'b1, segPattern(mDispWord[4*mDigit +: 4])};
         mAn     = ~(4'b0001 << mDigit);
         mScanOn = 1'b1;
      end
      if (mScanTick)
      begin
         mDigit    = mDigit + 2'd1;
         mScanning = 1'b1;
      end
      case (mDisp)
         3'd0: mDispWord = mTmr;
         3'd1: mDispWord = mArr;
         3'd2: mDispWord = mCtr;
         3'd3: mDispWord = mClkTest;
         3'd4: mDispWord = {16'd0, mSw};
         3'd5: mDispWord = {27'd0, mBtn};
         3'd6: mDispWord = {30'd0, mArReached, mRunning};
         default: mDispWord = 32'h0000_0123;   // Lamp test.
      endcase
      step = mRunning && countEn
             && (mCmd == boardPkg::cmdNone || mCmd == boardPkg::cmdToggleRun);
      hit = step && (mTmr == mArr);
      mArReached = hit;
      if (mCmd == boardPkg::cmdLoadArr)
      begin
         mArr = {16'd0, mSw};
         mTmr = '0;
      end
      else if (mCmd == boardPkg::cmdClear)
      begin
         mTmr = '0;
         mCtr = '0;
      end
      else if (hit)
      begin
         mTmr = '0;
         mCtr = mCtr + 32'd1;
      end
      else if (step)
         mTmr = mTmr + 32'd1;
      if (mCmd == boardPkg::cmdToggleRun)
         mRunning = ~mRunning;
      if (countEn)
         mClkTest = mClkTest + 32'd1;
      rise     = mBtn & ~mPrevBtn;
      mPrevBtn = mBtn;
      if (rise[boardPkg::BtnU])
         mCmd = boardPkg::cmdLoadArr;
      else if (rise[boardPkg::BtnD])
         mCmd = boardPkg::cmdClear;
      else if (rise[boardPkg::BtnC])
         mCmd = boardPkg::cmdToggleRun;
      else
         mCmd = boardPkg::cmdNone;
      if (mSampleTick)
      begin
         mSw   = sw;
         mBtn  = {btnL, btnR, btnU, btnD, btnC};
         mRate = sw[15:12];
         mDisp = sw[10:8];
      end
      mSampleTick = (mCyc % SampleDiv == SampleDiv - 1);
      mScanTick   = (mCyc % ScanDiv == ScanDiv - 1);
      for (int i = 0; i < Stages; i++)
         mStage[i] = (mCyc % decadePeriod(i) == decadePeriod(i) - 1);
      mCyc++;
   endtask

   always @(posedge selected_clk or posedge res)
   begin
      if (res)
         resetModel();
      else
         stepModel();
   end

   //////////////////////////////
   // Checks at the falling edge
   //////////////////////////////
   always @(negedge selected_clk)
   begin
      if (checksOn)
      begin
         if (leds !== mSw)
            reportMismatch("leds", leds, mSw);
         if (an !== mAn)
            reportMismatch("an", an, mAn);
         if (seg !== mSeg)
            reportMismatch("seg", seg, mSeg);
         if (mScanOn && $countones(~an) != 1)
         begin
            errors++;
            $display("Digit enables do not select exactly one digit, an is %h", an);
         end
         if (UUT.timer.tmr !== mTmr)
            reportMismatch("tmr", UUT.timer.tmr, mTmr);
         if (UUT.timer.arr !== mArr)
            reportMismatch("arr", UUT.timer.arr, mArr);
         if (UUT.timer.ctr !== mCtr)
            reportMismatch("ctr", UUT.timer.ctr, mCtr);
         if (UUT.timer.running !== mRunning)
            reportMismatch("running", UUT.timer.running, mRunning);
         if (UUT.timer.arReached !== mArReached)
            reportMismatch("arReached", UUT.timer.arReached, mArReached);
         if (UUT.clkTest !== mClkTest)
            reportMismatch("clkTest", UUT.clkTest, mClkTest);
         if (UUT.timer.arReached === 1'b1)
         begin
            if (periodClean)
            begin
               periodsChecked++;
               if (mCyc - lastReach != mArr + 1)
                  reportMismatch("reload period", mCyc - lastReach, mArr + 1);
            end
            lastReach   = mCyc;
            periodClean = 1'b1;
         end
         if (mCmd != boardPkg::cmdNone || !rateEnable(mRate, mStage) || !mRunning)
            periodClean = 1'b0;   // Period disturbed.
      end
   end

   initial
   begin
      logic [15:0] loadVal;
      int          hold;
      res            = 1'b1;
      sw             = '0;
      btnC           = 1'b0;
      btnU           = 1'b0;
      btnD           = 1'b0;
      btnL           = 1'b0;
      btnR           = 1'b0;
      errors         = 0;
      rng            = 32'd98318;
      checksOn       = 1'b0;
      lastReach      = 0;
      periodClean    = 1'b0;
      periodsChecked = 0;
      repeat (ResetCycles) @(posedge selected_clk);
      res      <= 1'b0;
      checksOn = 1'b1;
      @(negedge selected_clk);
      if (an !== 4'hF)
         reportMismatch("an", an, 32'hF);
      if (leds !== 16'h0000)
         reportMismatch("leds", leds, 32'h0);

      // Loads shown on the arr display with the timer held.
      for (int i = 0; i < LoadRounds; i++)
      begin
         rng = xorshift32(rng);
         press({4'h7, rng[11], 3'd1, rng[7:0]}, 5'b00100);
         driveFor({4'h7, rng[11], 3'd1, rng[7:0]}, 5'b00000, ViewCycles);
      end

      // Short reload value at full rate before the run.
      rng     = xorshift32(rng);
      loadVal = {12'h000, 4'(3 + rng[2:0])};
      press(loadVal, 5'b00100);
      press(loadVal, 5'b00001);
      driveFor(loadVal, 5'b00000, RunCycles);
      driveFor(loadVal | 16'h0200, 5'b00000, RunCycles);   // ctr
      driveFor(loadVal | 16'h0600, 5'b00000, RunCycles);   // Status word.

      // Random presses including collisions.
      for (int i = 0; i < PressRounds; i++)
      begin
         rng = xorshift32(rng);
         press({2'b00, rng[13:0]}, {rng[20:19], rng[18] & rng[21], rng[17:16]});
      end

      // Random rates with clkTest on the display.
      for (int i = 0; i < RateRounds; i++)
      begin
         rng  = xorshift32(rng);
         hold = 32 + int'(rng[7:0]);
         driveFor({rng[31:28], 1'b0, 3'd3, rng[15:8]}, 5'b00000, hold);
      end

      driveFor({4'h7, 1'b0, 3'd7, 8'h00}, 5'b00000, ViewCycles);
      @(negedge selected_clk);
      if (periodsChecked == 0)
      begin
         errors++;
         $display("No reload period was measured while the timer was running");
      end
      $display("Checks finished with %0d errors", errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // Watchdog.
   initial
   begin
      #((TestCycles + Margin) * ClkPeriod);
      $display("Timeout, the test sequence did not finish in time");
      $display("Regression failed");
      $finish;
   end

endmodule
